// ==== sim.f ====
common/conv_pkg.sv
verilog/conv_ctrl.sv
verilog/kernel_store.sv
conv_window/conv_window.sv
conv_mac/mac_array.sv
conv_mac/adder_tree.sv
verilog/conv_top.sv
sim/conv_props.sv
sim/conv_tb.sv

// ==== Bender.yml ====
package:
  name: conv3x3

sources:
  - common/conv_pkg.sv
  - verilog/conv_ctrl.sv
  - verilog/kernel_store.sv
  - conv_window/conv_window.sv
  - conv_mac/mac_array.sv
  - conv_mac/adder_tree.sv
  - verilog/conv_top.sv
  - target: simulation
    files:
      - sim/conv_props.sv
      - sim/conv_tb.sv

// ==== sim/conv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_tb;

  import conv_pkg::*;

  localparam int N_CASES     = 5;
  localparam int N_RESULTS   = (IMG_W - 2) * (IMG_H - 2);
  localparam int TIMEOUT_CYC = N_CASES * (64 + 40 + 9) + 100;
  localparam int HOLD_CYC    = 20;

  localparam logic [1:0] K_IDENT = 2'd0;
  localparam logic [1:0] K_ONES  = 2'd1;
  localparam logic [1:0] K_RAND  = 2'd2;
  localparam logic [1:0] K_MAX   = 2'd3;
  localparam logic [1:0] P_RAMP  = 2'd0;
  localparam logic [1:0] P_RAND  = 2'd1;
  localparam logic [1:0] P_MAX   = 2'd2;
  localparam logic       C_NOW   = 1'b0;
  localparam logic       C_LATE  = 1'b1;  // credits held back 20 cycles every 8 results

  typedef struct packed {
    logic [1:0] ksel;
    logic [1:0] pmode;
    logic       cmode;
  } frame_case_t;

  logic         clk;
  logic         rst;
  pixel_t       pix_in;
  logic         pix_valid;
  logic         pix_ready;
  coef_t        coef_in;
  logic         coef_valid;
  conv_result_t res;
  logic         res_valid;
  logic         res_credit;

  frame_case_t      cases [N_CASES];
  coef_t            kern [KERNEL_N];
  logic [PIX_W-1:0] frame [IMG_W*IMG_H];
  logic [SUM_W:0]   exp_q [$];  // last flag above the sum
  logic [SUM_W:0]   exp_word;
  logic [31:0]      lfsr = 32'h6ba8;
  logic             cur_cmode = C_NOW;
  int errors    = 0;
  int rcvd      = 0;
  int owed      = 0;  // results seen but not yet credited back
  int hold_cnt  = 0;
  int cycle_cnt = 0;
  int stalls;

  conv_top UUT (
    .clk        (clk),
    .rst        (rst),
    .pix_in     (pix_in),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .coef_in    (coef_in),
    .coef_valid (coef_valid),
    .res        (res),
    .res_valid  (res_valid),
    .res_credit (res_credit)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic rand_pixel(output logic [PIX_W-1:0] v);
    v = '0;
    for (int i = 0; i < PIX_W; i++) begin
      v    = {v[PIX_W-2:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic build_frame(input frame_case_t fc);
    for (int i = 0; i < KERNEL_N; i++) begin
      case (fc.ksel)
        K_IDENT: kern[i] = (i == 4) ? PIX_W'(1) : '0;
        K_ONES:  kern[i] = PIX_W'(1);
        K_RAND:  rand_pixel(kern[i]);
        default: kern[i] = '1;
      endcase
    end
    for (int i = 0; i < IMG_W * IMG_H; i++) begin
      case (fc.pmode)
        P_RAMP:  frame[i] = PIX_W'(i);
        P_RAND:  rand_pixel(frame[i]);
        default: frame[i] = '1;
      endcase
    end
  endtask

  // every full 3x3 block, position-wise products summed, in raster order
  task automatic push_expected;
    int sum;
    int n;
    n = 0;
    for (int r = 2; r < IMG_H; r++) begin
      for (int c = 2; c < IMG_W; c++) begin
        sum = 0;
        for (int dr = 0; dr < 3; dr++) begin
          for (int dc = 0; dc < 3; dc++) begin
            sum += int'(frame[(r - 2 + dr) * IMG_W + c - 2 + dc]) * int'(kern[dr * 3 + dc]);
          end
        end
        exp_q.push_back({(n == N_RESULTS - 1), SUM_W'(sum)});
        n++;
      end
    end
  endtask

  task automatic load_kernel;
    for (int i = 0; i < KERNEL_N; i++) begin
      coef_in    = kern[i];
      coef_valid = 1'b1;
      @(posedge clk);
      #0.5;
    end
    coef_valid = 1'b0;
    coef_in    = '0;
  endtask

  task automatic stream_frame(output int n_stall);
    logic ok;
    n_stall = 0;
    for (int i = 0; i < IMG_W * IMG_H; i++) begin
      pix_in.data = frame[i];
      pix_valid   = 1'b1;
      do begin
        @(negedge clk);
        ok = pix_ready;
        if (!ok) n_stall++;
        @(posedge clk);
        #0.5;
      end while (!ok);
    end
    pix_valid = 1'b0;
    pix_in    = '0;
  endtask

  // credit return driven after the edge, results checked at the falling edge
  initial begin
    res_credit = 1'b0;
    forever begin
      @(posedge clk);
      #0.5;
      if (hold_cnt > 0) begin
        res_credit = 1'b0;
        hold_cnt--;
      end else if (owed > 0) begin
        res_credit = 1'b1;
        owed--;
      end else begin
        res_credit = 1'b0;
      end
      @(negedge clk);
      if (res_valid) begin
        if (exp_q.size() == 0) begin
          $display("Error t=%0t a result arrived with no expected value left", $time);
          errors++;
        end else begin
          exp_word = exp_q.pop_front();
          if (res.sum !== exp_word[SUM_W-1:0]) begin
            $display("Fail t=%0t res.sum expected %0d got %0d", $time,
                     exp_word[SUM_W-1:0], res.sum);
            errors++;
          end
          if (res.last !== exp_word[SUM_W]) begin
            $display("Fail t=%0t res.last expected %0b got %0b", $time,
                     exp_word[SUM_W], res.last);
            errors++;
          end
        end
        rcvd++;
        owed++;
        if (owed > OUT_CREDITS) begin
          $display("Error t=%0t more results outstanding than credits allow", $time);
          errors++;
        end
        if (cur_cmode == C_LATE && rcvd % 8 == 0) hold_cnt = HOLD_CYC;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Error timeout after %0d cycles, %0d results seen", cycle_cnt, rcvd);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    pix_in     = '0;
    pix_valid  = 1'b0;
    coef_in    = '0;
    coef_valid = 1'b0;
    cases[0] = '{ksel: K_IDENT, pmode: P_RAMP, cmode: C_NOW};
    cases[1] = '{ksel: K_ONES,  pmode: P_RAMP, cmode: C_LATE};
    cases[2] = '{ksel: K_RAND,  pmode: P_RAND, cmode: C_NOW};
    cases[3] = '{ksel: K_RAND,  pmode: P_RAND, cmode: C_LATE};
    cases[4] = '{ksel: K_MAX,   pmode: P_MAX,  cmode: C_NOW};
    repeat (3) @(posedge clk);
    #0.5 rst = 1'b0;
    @(negedge clk);
    if (res_valid !== 1'b0) begin
      $display("Fail t=%0t res_valid expected 0 got %b", $time, res_valid);
      errors++;
    end
    if (pix_ready !== 1'b1) begin
      $display("Fail t=%0t pix_ready expected 1 got %b", $time, pix_ready);
      errors++;
    end
    @(posedge clk);
    #0.5;
    for (int k = 0; k < N_CASES; k++) begin
      cur_cmode = cases[k].cmode;
      build_frame(cases[k]);
      push_expected();
      load_kernel();
      stream_frame(stalls);
      if (cases[k].cmode == C_LATE && stalls == 0) begin
        $display("Error frame %0d pix_ready never dropped while credits were held", k);
        errors++;
      end
    end
    while (exp_q.size() != 0 || owed != 0) @(negedge clk);
    if (rcvd != N_CASES * N_RESULTS) begin
      $display("Error expected %0d results in total but saw %0d", N_CASES * N_RESULTS, rcvd);
      errors++;
    end
    $display("results %0d, errors %0d", rcvd, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/conv_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_props (
  input logic           clk,
  input logic           rst,
  input conv_pkg::tag_t win_tag,
  input logic           res_valid,
  input logic           res_credit
);

  import conv_pkg::*;

  int outstanding;  // results delivered and not yet credited back

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(res_valid) - int'(res_credit);
    end
  end

  // covers every reset cycle and the first one after release
  assert property (@(posedge clk) rst |=> !res_valid)
    else $error("res_valid high during or right after reset");

  assert property (@(posedge clk) disable iff (rst) outstanding <= OUT_CREDITS)
    else $error("results outstanding exceed the credit pool");

  assert property (@(posedge clk) disable iff (rst) win_tag.valid |-> ##3 res_valid)
    else $error("window-completing accept gave no result three cycles later");

  assert property (@(posedge clk) disable iff (rst) res_valid |-> $past(win_tag.valid, 3))
    else $error("result appeared without a window three cycles earlier");

endmodule

bind conv_top conv_props u_props (
  .clk        (clk),
  .rst        (rst),
  .win_tag    (win_tag),
  .res_valid  (res_valid),
  .res_credit (res_credit)
);

`default_nettype wire

// ==== verilog/conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_top (
  input  logic                   clk,
  input  logic                   rst,
  input  conv_pkg::pixel_t       pix_in,
  input  logic                   pix_valid,
  output logic                   pix_ready,
  input  conv_pkg::coef_t        coef_in,
  input  logic                   coef_valid,
  output conv_pkg::conv_result_t res,
  output logic                   res_valid,
  input  logic                   res_credit
);

  import conv_pkg::*;

  logic      accept;
  tag_t      win_tag;
  tag_t      prod_tag;
  kernel_t   kernel;
  window_t   window;
  prod_vec_t prod;

  conv_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .pix_valid  (pix_valid),
    .res_credit (res_credit),
    .pix_ready  (pix_ready),
    .accept     (accept),
    .win_tag    (win_tag)
  );

  kernel_store u_kernel (
    .clk        (clk),
    .rst        (rst),
    .coef_in    (coef_in),
    .coef_valid (coef_valid),
    .kernel     (kernel)
  );

  conv_window u_window (
    .clk    (clk),
    .rst    (rst),
    .accept (accept),
    .pix_in (pix_in),
    .window (window)
  );

  // window and tag line up here, three register stages to res_valid
  mac_array u_mac (
    .clk     (clk),
    .rst     (rst),
    .window  (window),
    .kernel  (kernel),
    .tag_in  (win_tag),
    .prod    (prod),
    .tag_out (prod_tag)
  );

  adder_tree u_tree (
    .clk       (clk),
    .rst       (rst),
    .prod      (prod),
    .tag_in    (prod_tag),
    .res       (res),
    .res_valid (res_valid)
  );

endmodule

`default_nettype wire

// ==== conv_mac/adder_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module adder_tree (
  input  logic                   clk,
  input  logic                   rst,
  input  conv_pkg::prod_vec_t    prod,
  input  conv_pkg::tag_t         tag_in,
  output conv_pkg::conv_result_t res,
  output logic                   res_valid
);

  import conv_pkg::*;

  logic [PROD_W:0]   pair_q [4];  // one extra bit per pair sum
  logic [PROD_W-1:0] odd_q;       // ninth product waits a stage
  tag_t              tag1_q;

  logic [SUM_W-1:0] sum_q;
  tag_t             tag2_q;

  always_ff @(posedge clk) begin
    pair_q[0] <= {1'b0, prod.p0} + {1'b0, prod.p1};
    pair_q[1] <= {1'b0, prod.p2} + {1'b0, prod.p3};
    pair_q[2] <= {1'b0, prod.p4} + {1'b0, prod.p5};
    pair_q[3] <= {1'b0, prod.p6} + {1'b0, prod.p7};
    odd_q     <= prod.p8;
  end

  // the full-width sum cannot overflow, nine 63*63 terms stay below 2**16
  always_ff @(posedge clk) begin
    sum_q <= SUM_W'(pair_q[0]) + SUM_W'(pair_q[1])
           + SUM_W'(pair_q[2]) + SUM_W'(pair_q[3])
           + SUM_W'(odd_q);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tag1_q <= '0;
      tag2_q <= '0;
    end else begin
      tag1_q <= tag_in;
      tag2_q <= tag1_q;
    end
  end

  always_comb begin
    res.sum  = sum_q;
    res.last = tag2_q.last;
  end

  assign res_valid = tag2_q.valid;

endmodule

`default_nettype wire

// ==== conv_mac/mac_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_array (
  input  logic                clk,
  input  logic                rst,
  input  conv_pkg::window_t   window,
  input  conv_pkg::kernel_t   kernel,
  input  conv_pkg::tag_t      tag_in,
  output conv_pkg::prod_vec_t prod,
  output conv_pkg::tag_t      tag_out
);

  import conv_pkg::*;

  prod_vec_t prod_d;
  prod_vec_t prod_q;
  tag_t      tag_q;

  // position-wise unsigned products, operands widened to keep the full 12 bits
  always_comb begin
    prod_d.p0 = PROD_W'(window.w0.data) * PROD_W'(kernel.k0);
    prod_d.p1 = PROD_W'(window.w1.data) * PROD_W'(kernel.k1);
    prod_d.p2 = PROD_W'(window.w2.data) * PROD_W'(kernel.k2);
    prod_d.p3 = PROD_W'(window.w3.data) * PROD_W'(kernel.k3);
    prod_d.p4 = PROD_W'(window.w4.data) * PROD_W'(kernel.k4);
    prod_d.p5 = PROD_W'(window.w5.data) * PROD_W'(kernel.k5);
    prod_d.p6 = PROD_W'(window.w6.data) * PROD_W'(kernel.k6);
    prod_d.p7 = PROD_W'(window.w7.data) * PROD_W'(kernel.k7);
    prod_d.p8 = PROD_W'(window.w8.data) * PROD_W'(kernel.k8);
  end

  always_ff @(posedge clk) begin
    prod_q <= prod_d;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_q <= '0;
    end else begin
      tag_q <= tag_in; // products are captured every cycle, the tag says which count
    end
  end

  assign prod    = prod_q;
  assign tag_out = tag_q;

endmodule

`default_nettype wire

// ==== conv_window/conv_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_window (
  input  logic              clk,
  input  logic              rst,
  input  logic              accept,
  input  conv_pkg::pixel_t  pix_in,
  output conv_pkg::window_t window
);

  import conv_pkg::*;

  // each line buffer delays by exactly one row of accepted pixels
  pixel_t lb0_q [IMG_W];
  pixel_t lb1_q [IMG_W];

  pixel_t lb0_out;  // same column, one row up
  pixel_t lb1_out;  // same column, two rows up

  // two older columns per window row, index 0 is the nearer one
  pixel_t top_q [2];
  pixel_t mid_q [2];
  pixel_t bot_q [2];

  assign lb0_out = lb0_q[IMG_W-1];
  assign lb1_out = lb1_q[IMG_W-1];

  always_ff @(posedge clk) begin
    if (accept) begin
      lb0_q[0] <= pix_in;
      lb1_q[0] <= lb0_out;
      for (int i = 1; i < IMG_W; i++) begin
        lb0_q[i] <= lb0_q[i-1];
        lb1_q[i] <= lb1_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2; i++) begin
        top_q[i] <= '0;
        mid_q[i] <= '0;
        bot_q[i] <= '0;
      end
    end else if (accept) begin
      top_q[0] <= lb1_out;
      mid_q[0] <= lb0_out;
      bot_q[0] <= pix_in;
      top_q[1] <= top_q[0];
      mid_q[1] <= mid_q[0];
      bot_q[1] <= bot_q[0];
    end
  end

  // the right column is live, so the window is complete in the accept cycle
  always_comb begin
    window.w0 = top_q[1];
    window.w1 = top_q[0];
    window.w2 = lb1_out;
    window.w3 = mid_q[1];
    window.w4 = mid_q[0];
    window.w5 = lb0_out;
    window.w6 = bot_q[1];
    window.w7 = bot_q[0];
    window.w8 = pix_in;
  end

endmodule

`default_nettype wire

// ==== verilog/kernel_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel_store (
  input  logic              clk,
  input  logic              rst,
  input  conv_pkg::coef_t   coef_in,
  input  logic              coef_valid,
  output conv_pkg::kernel_t kernel
);

  import conv_pkg::*;

  coef_t             coef_q [KERNEL_N];
  logic [KIDX_W-1:0] idx_q;  // next slot to be written

  always_ff @(posedge clk) begin
    if (rst) begin
      idx_q <= '0;
      for (int i = 0; i < KERNEL_N; i++) begin
        coef_q[i] <= '0;
      end
    end else if (coef_valid) begin
      coef_q[idx_q] <= coef_in;
      idx_q <= (idx_q == KIDX_W'(KERNEL_N - 1)) ? '0 : idx_q + 1'b1;
    end
  end

  always_comb begin
    kernel.k0 = coef_q[0];
    kernel.k1 = coef_q[1];
    kernel.k2 = coef_q[2];
    kernel.k3 = coef_q[3];
    kernel.k4 = coef_q[4];
    kernel.k5 = coef_q[5];
    kernel.k6 = coef_q[6];
    kernel.k7 = coef_q[7];
    kernel.k8 = coef_q[8];
  end

endmodule

`default_nettype wire

// ==== verilog/conv_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl (
  input  logic           clk,
  input  logic           rst,
  input  logic           pix_valid,
  input  logic           res_credit,
  output logic           pix_ready,
  output logic           accept,
  output conv_pkg::tag_t win_tag
);

  import conv_pkg::*;

  logic [COL_W-1:0]  col_q;
  logic [ROW_W-1:0]  row_q;
  logic [CRED_W-1:0] credits_q;

  logic completes;  // incoming position closes a full 3x3 window
  logic last_pos;
  logic take;       // a credit is reserved this cycle
  logic col_end;
  logic row_end;

  assign col_end   = (col_q == COL_W'(IMG_W - 1));
  assign row_end   = (row_q == ROW_W'(IMG_H - 1));
  assign completes = (row_q >= ROW_W'(2)) && (col_q >= COL_W'(2));
  assign last_pos  = row_end && col_end;

  // stall only when this pixel would need a result slot and none is free
  assign pix_ready = !(completes && (credits_q == '0));
  assign accept    = pix_valid && pix_ready;
  assign take      = accept && completes;

  always_comb begin
    win_tag.valid = take;
    win_tag.last  = take && last_pos;
  end

  // raster position, wrapping at the frame end so frames can follow directly
  always_ff @(posedge clk) begin
    if (rst) begin
      col_q <= '0;
      row_q <= '0;
    end else if (accept) begin
      if (col_end) begin
        col_q <= '0;
        if (row_end) begin
          row_q <= '0;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // a reservation and a returned credit in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      credits_q <= CRED_W'(OUT_CREDITS);
    end else begin
      case ({take, res_credit})
        2'b10: credits_q <= credits_q - 1'b1;
        2'b01: credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== common/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

  // frame geometry, fixed at 8x8
  localparam int IMG_W = 8;
  localparam int IMG_H = 8;

  localparam int PIX_W  = 6;   // pixel and coefficient width
  localparam int PROD_W = 12;
  localparam int SUM_W  = 18;

  localparam int OUT_CREDITS = 4; // result slots the downstream can hold

  localparam int COL_W    = $clog2(IMG_W);
  localparam int ROW_W    = $clog2(IMG_H);
  localparam int CRED_W   = $clog2(OUT_CREDITS + 1);
  localparam int KERNEL_N = 9;
  localparam int KIDX_W   = 4;

  typedef struct packed {
    logic [PIX_W-1:0] data;
  } pixel_t;

  typedef logic [PIX_W-1:0] coef_t;

  // w0 is the top-left pixel, w8 the bottom-right (the newest one)
  typedef struct packed {
    pixel_t w0, w1, w2;
    pixel_t w3, w4, w5;
    pixel_t w6, w7, w8;
  } window_t;

  typedef struct packed {
    coef_t k0, k1, k2;
    coef_t k3, k4, k5;
    coef_t k6, k7, k8;
  } kernel_t;

  typedef struct packed {
    logic [PROD_W-1:0] p0, p1, p2;
    logic [PROD_W-1:0] p3, p4, p5;
    logic [PROD_W-1:0] p6, p7, p8;
  } prod_vec_t;

  typedef struct packed {
    logic valid;
    logic last;
  } tag_t;

  typedef struct packed {
    logic [SUM_W-1:0] sum;
    logic             last;
  } conv_result_t;

endpackage

`default_nettype wire
